// ==== rv_pkg.sv ====
// RV32I only; no branch, JALR, FENCE or SYSTEM encodings, which the decode stage treats as illegal
package rv_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int unsigned XLEN   = 32;  // Data and address width
  localparam int unsigned REG_AW = 5;   // x0..x31

  //////////////////////////////
  // Major opcodes, instr[6:0]
  //////////////////////////////
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;

  // funct3 of SLL(I) in [0], of SRL(I)/SRA(I) in [1]
  localparam logic [1:0][2:0] FUNCT3_SLL_SRL = {3'b101, 3'b001};

  //////////////////////////////
  // ALU operation
  //////////////////////////////
  // Encoded as {instr[30], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_t;

  // LSU control, {store, funct3}
  // funct3 keeps width and sign of the access (LB/LH/LW/LBU/LHU, SB/SH/SW)
  typedef logic [3:0] lsu_ctrl_t;

  //////////////////////////////
  // Immediate formats
  //////////////////////////////
  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,  // Register-register, immediate is zero
    IMM_I    = 3'd1,
    IMM_ISH  = 3'd2,  // Shift amount only
    IMM_S    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5,
    IMM_FOUR = 3'd6   // Link address offset for JAL
  } imm_fmt_t;

  // Source registers an instruction reads, for the hazard check
  typedef enum logic [1:0] {
    SRC_NONE = 2'd0,
    SRC_RS1  = 2'd1,
    SRC_BOTH = 2'd2
  } hazard_src_t;

endpackage

// ==== rv_imm_gen.sv ====
// Purely combinational; shift amounts are zero-extended, every other format is sign-extended
module rv_imm_gen (
  input  logic [rv_pkg::XLEN-1:0] instr_i,
  input  rv_pkg::imm_fmt_t        imm_fmt_i,
  output logic [rv_pkg::XLEN-1:0] imm_o,
  output logic [rv_pkg::XLEN-1:0] jal_off_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] imm_i_ext;
  logic [XLEN-1:0] imm_ish_ext;
  logic [XLEN-1:0] imm_s_ext;
  logic [XLEN-1:0] imm_u_ext;
  logic [XLEN-1:0] imm_j_ext;

  //////////////////////////////
  // Format extraction
  //////////////////////////////
  assign imm_i_ext   = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_ish_ext = {27'b0, instr_i[24:20]};  // Unsigned shift amount
  assign imm_s_ext   = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_ext   = {instr_i[31:12], 12'b0};

  // J offset with bit 0 always zero
  assign imm_j_ext = {{11{instr_i[31]}},
                      instr_i[31],
                      instr_i[19:12],
                      instr_i[20],
                      instr_i[30:21],
                      1'b0};

  assign jal_off_o = imm_j_ext;  // Jump target goes straight to fetch

  //////////////////////////////
  // Format select
  //////////////////////////////
  always_comb begin
    case (imm_fmt_i)
      IMM_I:    imm_o = imm_i_ext;
      IMM_ISH:  imm_o = imm_ish_ext;
      IMM_S:    imm_o = imm_s_ext;
      IMM_U:    imm_o = imm_u_ext;
      IMM_FOUR: imm_o = XLEN'(4);  // pc + 4 for the link register
      default:  imm_o = '0;
    endcase
  end

endmodule

// ==== rv_op_decode.sv ====
// Decodes OP, OP-IMM, LUI, AUIPC, LOAD, STORE and JAL only; funct7 is not checked for legality
module rv_op_decode (
  input  logic [rv_pkg::XLEN-1:0]   instr_i,
  output logic                      illegal_o,
  output logic                      pc_sel_o,
  output rv_pkg::alu_op_t           alu_op_o,
  output logic                      alu_wb_o,
  output logic [rv_pkg::REG_AW-1:0] rd_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rs2_addr_o,
  output rv_pkg::imm_fmt_t          imm_fmt_o,
  output logic                      imm_b_o,
  output logic                      lsu_req_o,
  output rv_pkg::lsu_ctrl_t         lsu_ctrl_o,
  output logic                      jump_o,
  output rv_pkg::hazard_src_t       hazard_src_o,
  output logic [rv_pkg::REG_AW-1:0] dest_o
);
  import rv_pkg::*;

  logic [6:0]        opcode;
  logic [REG_AW-1:0] rd;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [2:0]        funct3;
  logic              is_shift;

  // Instruction fields
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  assign is_shift = (funct3 == FUNCT3_SLL_SRL[0]) || (funct3 == FUNCT3_SLL_SRL[1]);

  always_comb begin
    // Defaults match an illegal opcode
    illegal_o    = 1'b1;
    pc_sel_o     = 1'b0;
    alu_op_o     = ALU_ADD;
    alu_wb_o     = 1'b0;
    rd_addr_o    = '0;
    rs1_addr_o   = '0;
    rs2_addr_o   = '0;
    imm_fmt_o    = IMM_NONE;
    imm_b_o      = 1'b0;
    lsu_req_o    = 1'b0;
    lsu_ctrl_o   = '0;
    jump_o       = 1'b0;
    hazard_src_o = SRC_NONE;
    dest_o       = '0;

    case (opcode)
      OPC_OP: begin
        illegal_o    = 1'b0;
        alu_op_o     = alu_op_t'({instr_i[30], funct3});  // SUB/SRA via bit 30
        alu_wb_o     = 1'b1;
        rd_addr_o    = rd;
        rs1_addr_o   = rs1;
        rs2_addr_o   = rs2;
        hazard_src_o = SRC_BOTH;
        dest_o       = rd;
      end

      OPC_OPIMM: begin
        illegal_o    = 1'b0;
        alu_wb_o     = 1'b1;
        rd_addr_o    = rd;
        rs1_addr_o   = rs1;
        imm_b_o      = 1'b1;
        hazard_src_o = SRC_RS1;
        dest_o       = rd;
        if (is_shift) begin
          alu_op_o  = alu_op_t'({instr_i[30], funct3});  // SRAI keeps bit 30
          imm_fmt_o = IMM_ISH;
        end else begin
          // Bit 30 belongs to the immediate here
          alu_op_o  = alu_op_t'({1'b0, funct3});
          imm_fmt_o = IMM_I;
        end
      end

      OPC_LUI: begin
        illegal_o = 1'b0;
        alu_wb_o  = 1'b1;  // x0 + U immediate
        rd_addr_o = rd;
        imm_fmt_o = IMM_U;
        imm_b_o   = 1'b1;
        dest_o    = rd;
      end

      OPC_AUIPC: begin
        illegal_o = 1'b0;
        pc_sel_o  = 1'b1;  // pc + U immediate
        alu_wb_o  = 1'b1;
        rd_addr_o = rd;
        imm_fmt_o = IMM_U;
        imm_b_o   = 1'b1;
        dest_o    = rd;
      end

      OPC_LOAD: begin
        illegal_o    = 1'b0;
        rd_addr_o    = rd;  // Written back by the LSU
        rs1_addr_o   = rs1;
        imm_fmt_o    = IMM_I;
        imm_b_o      = 1'b1;
        lsu_req_o    = 1'b1;
        lsu_ctrl_o   = {1'b0, funct3};
        hazard_src_o = SRC_RS1;
        dest_o       = rd;
      end

      OPC_STORE: begin
        illegal_o    = 1'b0;
        rs1_addr_o   = rs1;  // Base address
        rs2_addr_o   = rs2;  // Store data
        imm_fmt_o    = IMM_S;
        imm_b_o      = 1'b1;
        lsu_req_o    = 1'b1;
        lsu_ctrl_o   = {1'b1, funct3};
        hazard_src_o = SRC_BOTH;
      end

      OPC_JAL: begin
        illegal_o = 1'b0;
        pc_sel_o  = 1'b1;  // Link value is pc + 4
        alu_wb_o  = 1'b1;
        rd_addr_o = rd;
        imm_fmt_o = IMM_FOUR;
        imm_b_o   = 1'b1;
        jump_o    = 1'b1;
        dest_o    = rd;
      end

      default: ;  // Keep the illegal defaults
    endcase
  end

endmodule

// ==== rv_hazard_fsm.sv ====
// Checks RAW hazards against the previous accepted instruction only; one stall cycle per hazard
module rv_hazard_fsm (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      instr_valid_i,
  input  logic                      illegal_i,
  input  logic                      jump_i,
  input  logic [rv_pkg::REG_AW-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_AW-1:0] rs2_addr_i,
  input  rv_pkg::hazard_src_t       hazard_src_i,
  input  logic [rv_pkg::REG_AW-1:0] dest_i,
  input  logic [rv_pkg::XLEN-1:0]   jal_off_i,
  output logic                      ready_o,
  output logic                      stall_o,
  output logic                      jump_o,
  output logic [rv_pkg::XLEN-1:0]   jump_offset_o
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    ST_OK    = 2'd0,
    ST_STALL = 2'd1,
    ST_JUMP  = 2'd2,
    ST_ERROR = 2'd3
  } dec_state_t;

  dec_state_t        curr_state;
  dec_state_t        prev_state_q;  // State of the last valid cycle
  logic [REG_AW-1:0] prev_dest_q;
  logic              rs1_hit;
  logic              rs2_hit;

  //////////////////////////////
  // Hazard detection
  //////////////////////////////
  // x0 never causes a stall
  assign rs1_hit = (hazard_src_i != SRC_NONE) && (rs1_addr_i != '0) &&
                   (rs1_addr_i == prev_dest_q);
  assign rs2_hit = (hazard_src_i == SRC_BOTH) && (rs2_addr_i != '0) &&
                   (rs2_addr_i == prev_dest_q);

  always_comb begin
    if (!instr_valid_i) begin
      curr_state = ST_OK;
    end else if (illegal_i) begin
      curr_state = ST_ERROR;
    end else if (jump_i) begin
      curr_state = ST_JUMP;  // JAL reads no registers
    end else if ((rs1_hit || rs2_hit) && (prev_state_q != ST_STALL)) begin
      curr_state = ST_STALL;  // Repeat passes after one cycle
    end else begin
      curr_state = ST_OK;
    end
  end

  assign ready_o       = (curr_state == ST_OK) || (curr_state == ST_JUMP);
  assign stall_o       = (curr_state == ST_STALL);
  assign jump_o        = (curr_state == ST_JUMP);
  assign jump_offset_o = jump_o ? jal_off_i : '0;

  //////////////////////////////
  // History
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_state_q <= ST_OK;
      prev_dest_q  <= '0;
    end else if (instr_valid_i) begin
      prev_state_q <= curr_state;
      prev_dest_q  <= dest_i;  // Zero for stores and illegal opcodes
    end
  end

endmodule

// ==== rv_decode_reg.sv ====
// Captures every valid decode, stalled or not; fields hold while idle except pc_sel, which clears
module rv_decode_reg (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      instr_valid_i,
  input  logic                      stall_i,
  input  logic                      pc_sel_i,
  input  logic                      illegal_i,
  input  rv_pkg::alu_op_t           alu_op_i,
  input  logic                      alu_wb_i,
  input  logic [rv_pkg::REG_AW-1:0] rd_addr_i,
  input  logic [rv_pkg::REG_AW-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_AW-1:0] rs2_addr_i,
  input  logic [rv_pkg::XLEN-1:0]   imm_i,
  input  logic                      imm_b_i,
  input  logic                      lsu_req_i,
  input  rv_pkg::lsu_ctrl_t         lsu_ctrl_i,
  input  logic [rv_pkg::XLEN-1:0]   instr_addr_i,
  output logic                      pc_sel_o,
  output logic                      illegal_o,
  output rv_pkg::alu_op_t           alu_op_o,
  output logic                      alu_wb_o,
  output logic [rv_pkg::REG_AW-1:0] rd_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rs2_addr_o,
  output logic [rv_pkg::XLEN-1:0]   imm_o,
  output logic                      imm_b_o,
  output logic                      lsu_req_o,
  output rv_pkg::lsu_ctrl_t         lsu_ctrl_o,
  output logic [rv_pkg::XLEN-1:0]   instr_addr_o
);
  import rv_pkg::*;

  //////////////////////////////
  // Decode capture
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pc_sel_o   <= 1'b0;
      illegal_o  <= 1'b0;
      alu_op_o   <= ALU_ADD;
      alu_wb_o   <= 1'b0;
      rd_addr_o  <= '0;
      rs1_addr_o <= '0;
      rs2_addr_o <= '0;
      imm_o      <= '0;
      imm_b_o    <= 1'b0;
      lsu_req_o  <= 1'b0;
      lsu_ctrl_o <= '0;
    end else if (instr_valid_i) begin
      pc_sel_o   <= pc_sel_i;
      illegal_o  <= illegal_i;
      alu_op_o   <= alu_op_i;
      alu_wb_o   <= alu_wb_i & ~stall_i;  // No side effects on a stall
      rd_addr_o  <= rd_addr_i;
      rs1_addr_o <= rs1_addr_i;
      rs2_addr_o <= rs2_addr_i;
      imm_o      <= imm_i;
      imm_b_o    <= imm_b_i;
      lsu_req_o  <= lsu_req_i & ~stall_i;
      lsu_ctrl_o <= lsu_ctrl_i;
    end else begin
      pc_sel_o <= 1'b0;  // Rest of the fields hold
    end
  end

  // Address follows fetch every cycle
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_addr_o <= '0;
    end else begin
      instr_addr_o <= instr_addr_i;
    end
  end

endmodule

// ==== rv_decoder.sv ====
// Fetch must hold the instruction while ready_o is low; an illegal opcode keeps ready_o low
module rv_decoder (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      instr_valid_i,
  input  logic [rv_pkg::XLEN-1:0]   instr_i,
  input  logic [rv_pkg::XLEN-1:0]   instr_addr_i,
  output logic                      ready_o,
  output logic                      jump_o,
  output logic [rv_pkg::XLEN-1:0]   jump_offset_o,
  output logic                      pc_sel_o,
  output logic                      illegal_o,
  output rv_pkg::alu_op_t           alu_op_o,
  output logic                      alu_wb_o,
  output logic [rv_pkg::REG_AW-1:0] rd_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_AW-1:0] rs2_addr_o,
  output logic [rv_pkg::XLEN-1:0]   imm_o,
  output logic                      imm_b_o,
  output logic                      lsu_req_o,
  output rv_pkg::lsu_ctrl_t         lsu_ctrl_o,
  output logic [rv_pkg::XLEN-1:0]   instr_addr_o
);
  import rv_pkg::*;

  // Raw decode, same cycle as the instruction
  logic              dec_illegal;
  logic              dec_pc_sel;
  alu_op_t           dec_alu_op;
  logic              dec_alu_wb;
  logic [REG_AW-1:0] dec_rd;
  logic [REG_AW-1:0] dec_rs1;
  logic [REG_AW-1:0] dec_rs2;
  imm_fmt_t          dec_imm_fmt;
  logic              dec_imm_b;
  logic              dec_lsu_req;
  lsu_ctrl_t         dec_lsu_ctrl;
  logic              dec_jump;
  hazard_src_t       dec_hazard_src;
  logic [REG_AW-1:0] dec_dest;
  logic [XLEN-1:0]   dec_imm;
  logic [XLEN-1:0]   dec_jal_off;
  logic              stall;

  //////////////////////////////
  // Decode
  //////////////////////////////
  rv_op_decode i_op_decode (
    .instr_i      (instr_i),
    .illegal_o    (dec_illegal),
    .pc_sel_o     (dec_pc_sel),
    .alu_op_o     (dec_alu_op),
    .alu_wb_o     (dec_alu_wb),
    .rd_addr_o    (dec_rd),
    .rs1_addr_o   (dec_rs1),
    .rs2_addr_o   (dec_rs2),
    .imm_fmt_o    (dec_imm_fmt),
    .imm_b_o      (dec_imm_b),
    .lsu_req_o    (dec_lsu_req),
    .lsu_ctrl_o   (dec_lsu_ctrl),
    .jump_o       (dec_jump),
    .hazard_src_o (dec_hazard_src),
    .dest_o       (dec_dest)
  );

  rv_imm_gen i_imm_gen (
    .instr_i   (instr_i),
    .imm_fmt_i (dec_imm_fmt),
    .imm_o     (dec_imm),
    .jal_off_o (dec_jal_off)
  );

  //////////////////////////////
  // Handshake and jump
  //////////////////////////////
  rv_hazard_fsm i_hazard_fsm (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .illegal_i     (dec_illegal),
    .jump_i        (dec_jump),
    .rs1_addr_i    (dec_rs1),
    .rs2_addr_i    (dec_rs2),
    .hazard_src_i  (dec_hazard_src),
    .dest_i        (dec_dest),
    .jal_off_i     (dec_jal_off),
    .ready_o       (ready_o),
    .stall_o       (stall),
    .jump_o        (jump_o),
    .jump_offset_o (jump_offset_o)
  );

  //////////////////////////////
  // Output register
  //////////////////////////////
  rv_decode_reg i_decode_reg (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall),
    .pc_sel_i      (dec_pc_sel),
    .illegal_i     (dec_illegal),
    .alu_op_i      (dec_alu_op),
    .alu_wb_i      (dec_alu_wb),
    .rd_addr_i     (dec_rd),
    .rs1_addr_i    (dec_rs1),
    .rs2_addr_i    (dec_rs2),
    .imm_i         (dec_imm),
    .imm_b_i       (dec_imm_b),
    .lsu_req_i     (dec_lsu_req),
    .lsu_ctrl_i    (dec_lsu_ctrl),
    .instr_addr_i  (instr_addr_i),
    .pc_sel_o      (pc_sel_o),
    .illegal_o     (illegal_o),
    .alu_op_o      (alu_op_o),
    .alu_wb_o      (alu_wb_o),
    .rd_addr_o     (rd_addr_o),
    .rs1_addr_o    (rs1_addr_o),
    .rs2_addr_o    (rs2_addr_o),
    .imm_o         (imm_o),
    .imm_b_o       (imm_b_o),
    .lsu_req_o     (lsu_req_o),
    .lsu_ctrl_o    (lsu_ctrl_o),
    .instr_addr_o  (instr_addr_o)
  );

endmodule

// ==== tb_checker.sv ====
// Combinational outputs are compared at the falling edge, registered ones 1 ns after the next rise
module tb_checker (
  input  logic                          clk_i,
  input  logic                          active_i,
  input  logic                          done_i,
  input  int                            test_i,
  input  logic [14:0][rv_pkg::XLEN-1:0] exp_i,  // Expected, 3 combinational then 12 registered
  input  logic [14:0][rv_pkg::XLEN-1:0] act_i,  // DUT outputs, same order
  output int                            passed_o,
  output int                            failed_o,
  output logic                          report_done_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int NUM_COMB = 3;  // ready, jump, jump offset
  localparam int NUM_CHK  = 15;

  string field_name [0:NUM_CHK-1] = '{
    "ready_o", "jump_o", "jump_offset_o", "pc_sel_o", "illegal_o",
    "alu_op_o", "alu_wb_o", "rd_addr_o", "rs1_addr_o", "rs2_addr_o",
    "imm_o", "imm_b_o", "lsu_req_o", "lsu_ctrl_o", "instr_addr_o"
  };

  int cur_test;   // 0 until the first vector
  int test_errs;

  //////////////////////////////
  // Compare and report
  //////////////////////////////
  task automatic compare_range(input int first, input int last);
    for (int k = first; k <= last; k++) begin
      if (act_i[k] !== exp_i[k]) begin
        $display("Mismatch at %0d ns: test %0d, %s expected 0x%08h, got 0x%08h",
                 $time, cur_test, field_name[k], exp_i[k], act_i[k]);
        test_errs++;
      end
    end
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      passed_o++;
      $display("Test %0d done: passed", cur_test);
    end else begin
      failed_o++;
      $display("Test %0d done: failed with %0d mismatches", cur_test, test_errs);
    end
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////
  initial begin
    passed_o      = 0;
    failed_o      = 0;
    report_done_o = 1'b0;
    cur_test      = 0;
    test_errs     = 0;
    while (!report_done_o) begin
      @(negedge clk_i);  // Inputs settled since the drive
      if (done_i) begin
        if (cur_test != 0) begin
          close_test();
        end
        report_done_o = 1'b1;
      end else if (active_i) begin
        // New test number closes the previous test
        if (test_i != cur_test) begin
          if (cur_test != 0) begin
            close_test();
          end
          cur_test  = test_i;
          test_errs = 0;
        end
        compare_range(0, NUM_COMB - 1);
        @(posedge clk_i);
        #1;
        compare_range(NUM_COMB, NUM_CHK - 1);  // Expected values still held here
      end
    end
  end

endmodule

// ==== tb_decoder.sv ====
// Needs decoder_vectors.txt in the run directory; a line that does not open with a hex value is skipped
module tb_decoder;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;  // Inputs change after the rising edge
  localparam int RESET_CYCLES = 10;
  localparam int MAX_VECS     = 64;
  localparam int NUM_COLS     = 19;  // 4 stimulus + 15 expected
  localparam int NUM_EXP      = 15;
  localparam int RAND_SEED    = 55;

  logic                  clk;
  logic                  rstn;
  logic                  instr_valid;
  logic [XLEN-1:0]       instr;
  logic [XLEN-1:0]       instr_addr;
  logic                  ready;
  logic                  jump;
  logic [XLEN-1:0]       jump_offset;
  logic                  pc_sel;
  logic                  illegal;
  alu_op_t               alu_op;
  logic                  alu_wb;
  logic [REG_AW-1:0]     rd_addr;
  logic [REG_AW-1:0]     rs1_addr;
  logic [REG_AW-1:0]     rs2_addr;
  logic [XLEN-1:0]       imm;
  logic                  imm_b;
  logic                  lsu_req;
  lsu_ctrl_t             lsu_ctrl;
  logic [XLEN-1:0]       dec_instr_addr;
  logic [XLEN-1:0]       vec_mem [0:MAX_VECS-1][0:NUM_COLS-1];
  logic [14:0][XLEN-1:0] exp_val;
  logic [14:0][XLEN-1:0] act_val;
  int                    n_vecs;
  int                    load_errors;
  int                    test_num;
  int                    passed;
  int                    failed;
  logic                  active;
  logic                  done;
  logic                  report_done;
  logic                  loaded;

  // Same order as the expected columns of the vector file
  assign act_val[0]  = {31'b0, ready};
  assign act_val[1]  = {31'b0, jump};
  assign act_val[2]  = jump_offset;
  assign act_val[3]  = {31'b0, pc_sel};
  assign act_val[4]  = {31'b0, illegal};
  assign act_val[5]  = {28'b0, alu_op};
  assign act_val[6]  = {31'b0, alu_wb};
  assign act_val[7]  = {27'b0, rd_addr};
  assign act_val[8]  = {27'b0, rs1_addr};
  assign act_val[9]  = {27'b0, rs2_addr};
  assign act_val[10] = imm;
  assign act_val[11] = {31'b0, imm_b};
  assign act_val[12] = {31'b0, lsu_req};
  assign act_val[13] = {28'b0, lsu_ctrl};
  assign act_val[14] = dec_instr_addr;

  rv_decoder i_dut (
    .clk_i         (clk),
    .rstn_i        (rstn),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .instr_addr_i  (instr_addr),
    .ready_o       (ready),
    .jump_o        (jump),
    .jump_offset_o (jump_offset),
    .pc_sel_o      (pc_sel),
    .illegal_o     (illegal),
    .alu_op_o      (alu_op),
    .alu_wb_o      (alu_wb),
    .rd_addr_o     (rd_addr),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .imm_o         (imm),
    .imm_b_o       (imm_b),
    .lsu_req_o     (lsu_req),
    .lsu_ctrl_o    (lsu_ctrl),
    .instr_addr_o  (dec_instr_addr)
  );

  tb_checker i_checker (
    .clk_i         (clk),
    .active_i      (active),
    .done_i        (done),
    .test_i        (test_num),
    .exp_i         (exp_val),
    .act_i         (act_val),
    .passed_o      (passed),
    .failed_o      (failed),
    .report_done_o (report_done)
  );

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    wait (loaded);
    #((n_vecs + 20) * CLK_PERIOD);
    $display("Error: timeout, the run did not end within %0d cycles", n_vecs + 20);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////
  // Vector file
  //////////////////////////////
  task automatic load_vectors();
    int               fd;
    int               cnt;
    logic [XLEN-1:0]  col [0:NUM_COLS-1];
    logic [8*256-1:0] rest;
    fd = $fopen("decoder_vectors.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open the vector file decoder_vectors.txt");
      load_errors++;
      return;
    end
    while (!$feof(fd) && (n_vecs < MAX_VECS)) begin
      cnt = $fscanf(fd, "%h", col[0]);
      if (cnt == 1) begin
        cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                      col[9], col[10], col[11], col[12], col[13], col[14], col[15],
                      col[16], col[17], col[18]);
        if (cnt != NUM_COLS - 1) begin
          $display("Error: malformed vector line in test %0d", col[0]);
          load_errors++;
          break;
        end
        for (int k = 0; k < NUM_COLS; k++) begin
          vec_mem[n_vecs][k] = col[k];
        end
        n_vecs++;
      end else if (cnt == 0) begin
        cnt = $fgets(rest, fd);  // Comment line
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_vector(input int idx);
    test_num    = vec_mem[idx][0];
    instr_valid = vec_mem[idx][1][0];
    instr       = instr_valid ? vec_mem[idx][2] : $urandom;  // Noise while idle
    instr_addr  = vec_mem[idx][3];
    for (int k = 0; k < NUM_EXP; k++) begin
      exp_val[k] = vec_mem[idx][k + 4];
    end
    active = 1'b1;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin : stimulus
    int seed_val;
    rstn        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    instr_addr  = '0;
    exp_val     = '0;
    active      = 1'b0;
    done        = 1'b0;
    loaded      = 1'b0;
    n_vecs      = 0;
    load_errors = 0;
    test_num    = 0;
    seed_val    = $urandom(RAND_SEED);
    load_vectors();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rstn = 1'b1;
    for (int i = 0; i < n_vecs; i++) begin
      apply_vector(i);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    active      = 1'b0;
    instr_valid = 1'b0;
    done        = 1'b1;
    wait (report_done);
    $display("Tests passed: %0d, failed: %0d, file errors: %0d", passed, failed, load_errors);
    if ((failed == 0) && (load_errors == 0) && (passed > 0)) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== decoder_vectors.txt ====
# test valid instr addr ready jump jump_off pc_sel illegal alu_op alu_wb rd rs1 rs2 imm imm_b lsu_req lsu_ctrl instr_addr_o
# all hex; columns from pc_sel on are expected one clock later; instr is random while valid is 0
1 0 00000000 00000000 1 0 00000000 0 0 0 0 00 00 00 00000000 0 0 0 00000000
1 0 00000000 00000000 1 0 00000000 0 0 0 0 00 00 00 00000000 0 0 0 00000000
2 1 003100b3 00000100 1 0 00000000 0 0 0 1 01 02 03 00000000 0 0 0 00000100
2 1 40628233 00000104 1 0 00000000 0 0 8 1 04 05 06 00000000 0 0 0 00000104
2 1 40345393 00000108 1 0 00000000 0 0 d 1 07 08 00 00000003 1 0 0 00000108
2 1 ffb50493 0000010c 1 0 00000000 0 0 0 1 09 0a 00 fffffffb 1 0 0 0000010c
2 1 123455b7 00000110 1 0 00000000 0 0 0 1 0b 00 00 12345000 1 0 0 00000110
2 1 fffff617 00000114 1 0 00000000 1 0 0 1 0c 00 00 fffff000 1 0 0 00000114
2 1 ff871683 00000118 1 0 00000000 0 0 0 0 0d 0e 00 fffffff8 1 1 1 00000118
2 1 00f82a23 0000011c 1 0 00000000 0 0 0 0 00 10 0f 00000014 1 1 a 0000011c
3 1 002082b3 00000120 1 0 00000000 0 0 0 1 05 01 02 00000000 0 0 0 00000120
3 1 00128313 00000124 0 0 00000000 0 0 0 0 06 05 00 00000001 1 0 0 00000124
3 1 00128313 00000124 1 0 00000000 0 0 0 1 06 05 00 00000001 1 0 0 00000124
3 1 00218013 00000128 1 0 00000000 0 0 0 1 00 03 00 00000002 1 0 0 00000128
3 1 00000433 0000012c 1 0 00000000 0 0 0 1 08 00 00 00000000 0 0 0 0000012c
3 1 00b50023 00000130 1 0 00000000 0 0 0 0 00 0a 0b 00000000 1 1 8 00000130
3 1 00b50633 00000134 1 0 00000000 0 0 0 1 0c 0a 0b 00000000 0 0 0 00000134
3 1 00462683 00000138 0 0 00000000 0 0 0 0 0d 0c 00 00000004 1 0 2 00000138
3 1 00462683 00000138 1 0 00000000 0 0 0 0 0d 0c 00 00000004 1 1 2 00000138
4 1 b99fd0ef 0000013c 1 1 ffffdb98 1 0 0 1 01 00 00 00000004 1 0 0 0000013c
4 1 0080006f 00000140 1 1 00000008 1 0 0 1 00 00 00 00000004 1 0 0 00000140
5 0 00000000 00000200 1 0 00000000 0 0 0 1 00 00 00 00000004 1 0 0 00000200
5 0 00000000 00000204 1 0 00000000 0 0 0 1 00 00 00 00000004 1 0 0 00000204
5 0 00000000 00000208 1 0 00000000 0 0 0 1 00 00 00 00000004 1 0 0 00000208
6 1 00208063 0000020c 0 0 00000000 0 1 0 0 00 00 00 00000000 0 0 0 0000020c
6 1 00000073 00000210 0 0 00000000 0 1 0 0 00 00 00 00000000 0 0 0 00000210
6 1 003100b3 00000214 1 0 00000000 0 0 0 1 01 02 03 00000000 0 0 0 00000214

// ==== sim.f ====
rv_pkg.sv
rv_imm_gen.sv
rv_op_decode.sv
rv_hazard_fsm.sv
rv_decode_reg.sv
rv_decoder.sv
tb_checker.sv
tb_decoder.sv
